//--- hdl/rbf_pkg.sv
package rbf_pkg;

  // Input samples: x and grid are signed Q3.12, scale is unsigned Q4.12
  localparam int sample_width = 16;
  localparam int sample_frac  = 12;
  localparam int scale_frac   = 12;

  // |x - grid| needs one more bit than a sample
  localparam int mag_width  = sample_width + 1;
  localparam int prod_width = mag_width + sample_width;
  localparam int prod_frac  = sample_frac + scale_frac;

  // ROM address is Q3.5, the top entry means beyond the table
  localparam int addr_width = 8;
  localparam int addr_frac  = 5;
  localparam int addr_shift = prod_frac - addr_frac;

  // Result is unsigned Q1.15
  localparam int rslt_width = 16;
  localparam int rslt_frac  = 15;

  typedef struct packed {
    logic [sample_width-1:0] value;
    logic                    last;
  } sample_t;

  typedef struct packed {
    logic [prod_width-1:0] value;
    logic                  last;
  } prod_t;

  typedef struct packed {
    logic [addr_width-1:0] value;
    logic                  last;
  } addr_t;

  typedef struct packed {
    logic [rslt_width-1:0] value;
    logic                  last;
  } rslt_t;

endpackage

//--- hdl/scaled_diff.sv
`timescale 1ns/1ps

module scaled_diff (
  input  logic             clk,
  input  logic             rst_n,

  input  rbf_pkg::sample_t x_beat,
  input  logic             x_valid,
  output logic             x_ready,

  input  rbf_pkg::sample_t grid_beat,
  input  logic             grid_valid,
  output logic             grid_ready,

  input  rbf_pkg::sample_t scale_beat,
  input  logic             scale_valid,
  output logic             scale_ready,

  output rbf_pkg::prod_t   prod_beat,
  output logic             prod_valid,
  input  logic             prod_ready
);

  logic                                 join_ready;
  logic                                 take_in;
  logic signed [rbf_pkg::mag_width-1:0] diff;
  logic [rbf_pkg::mag_width-1:0]        mag;

  // Stage one holds the magnitude next to its scale
  logic                                 mid_valid;
  logic                                 mid_ready;
  logic                                 take_mid;
  logic [rbf_pkg::mag_width-1:0]        mag_q;
  logic [rbf_pkg::sample_width-1:0]     scale_q;
  logic                                 last_q;

  assign mid_ready  = !prod_valid || prod_ready;
  assign join_ready = !mid_valid || mid_ready;
  assign take_mid   = mid_valid && mid_ready;

  // All three beats move together or none does
  assign take_in     = x_valid && grid_valid && scale_valid && join_ready;
  assign x_ready     = take_in;
  assign grid_ready  = take_in;
  assign scale_ready = take_in;

  // Sign extend before subtracting so the full range fits
  assign diff = $signed({x_beat.value[rbf_pkg::sample_width-1], x_beat.value}) -
                $signed({grid_beat.value[rbf_pkg::sample_width-1], grid_beat.value});

  assign mag = diff[rbf_pkg::mag_width-1] ? $unsigned(-diff) : $unsigned(diff);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mid_valid  <= 1'b0;
      prod_valid <= 1'b0;
    end else begin
      if (join_ready) begin
        mid_valid <= take_in;
      end
      if (mid_ready) begin
        prod_valid <= mid_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      mag_q   <= mag;
      scale_q <= scale_beat.value;
      last_q  <= x_beat.last | grid_beat.last | scale_beat.last;
    end
    // Unsigned product with 24 fractional bits
    if (take_mid) begin
      prod_beat.value <= rbf_pkg::prod_width'(mag_q) * rbf_pkg::prod_width'(scale_q);
      prod_beat.last  <= last_q;
    end
  end

endmodule

//--- hdl/diff_clamp.sv
`timescale 1ns/1ps

module diff_clamp (
  input  logic           clk,
  input  logic           rst_n,

  input  rbf_pkg::prod_t prod_beat,
  input  logic           prod_valid,
  output logic           prod_ready,

  output rbf_pkg::addr_t addr_beat,
  output logic           addr_valid,
  input  logic           addr_ready
);

  localparam int shifted_width = rbf_pkg::prod_width - rbf_pkg::addr_shift;

  logic                             take;
  logic [shifted_width-1:0]         shifted;
  logic                             over;
  logic [rbf_pkg::addr_width-1:0]   addr_sat;

  assign prod_ready = !addr_valid || addr_ready;
  assign take       = prod_valid && prod_ready;

  // Drop fractional bits down to the address grid
  assign shifted = prod_beat.value[rbf_pkg::prod_width-1:rbf_pkg::addr_shift];

  // Anything past the table lands on the top entry
  assign over     = |shifted[shifted_width-1:rbf_pkg::addr_width];
  assign addr_sat = over ? '1 : shifted[rbf_pkg::addr_width-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_valid <= 1'b0;
    end else if (prod_ready) begin
      addr_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      addr_beat.value <= addr_sat;
      addr_beat.last  <= prod_beat.last;
    end
  end

endmodule

//--- hdl/rbf_rom.sv
`timescale 1ns/1ps

module rbf_rom (
  input  logic           clk,
  input  logic           rst_n,

  input  rbf_pkg::addr_t addr_beat,
  input  logic           addr_valid,
  output logic           addr_ready,

  output rbf_pkg::rslt_t rslt_beat,
  output logic           rslt_valid,
  input  logic           rslt_ready
);

  localparam int depth = 1 << rbf_pkg::addr_width;

  logic                           take;
  logic [rbf_pkg::rslt_width-1:0] sech2_tab [depth];

  // round(2^15 * sech^2(a / 2^5)), top entry stands for infinity
  function automatic logic [rbf_pkg::rslt_width-1:0] sech2_entry(input int a);
    real x;
    real e_sum;
    real v;
    x     = real'(a) / real'(1 << rbf_pkg::addr_frac);
    e_sum = $exp(x) + $exp(-x);
    v     = real'(1 << rbf_pkg::rslt_frac) * 4.0 / (e_sum * e_sum);
    if (a == depth - 1) begin
      return '0;
    end
    return rbf_pkg::rslt_width'($rtoi(v + 0.5));
  endfunction

  for (genvar a = 0; a < depth; a++) begin : g_tab
    localparam logic [rbf_pkg::rslt_width-1:0] entry = sech2_entry(a);
    assign sech2_tab[a] = entry;
  end

  assign addr_ready = !rslt_valid || rslt_ready;
  assign take       = addr_valid && addr_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rslt_valid <= 1'b0;
    end else if (addr_ready) begin
      rslt_valid <= addr_valid;
    end
  end

  // Registered read
  always_ff @(posedge clk) begin
    if (take) begin
      rslt_beat.value <= sech2_tab[addr_beat.value];
      rslt_beat.last  <= addr_beat.last;
    end
  end

endmodule

//--- hdl/rbf_unit.sv
`timescale 1ns/1ps

module rbf_unit (
  input  logic             clk,
  input  logic             rst_n,

  input  rbf_pkg::sample_t x_beat,
  input  logic             x_valid,
  output logic             x_ready,

  input  rbf_pkg::sample_t grid_beat,
  input  logic             grid_valid,
  output logic             grid_ready,

  input  rbf_pkg::sample_t scale_beat,
  input  logic             scale_valid,
  output logic             scale_ready,

  output rbf_pkg::rslt_t   rslt_beat,
  output logic             rslt_valid,
  input  logic             rslt_ready
);

  rbf_pkg::prod_t prod_beat;
  logic           prod_valid;
  logic           prod_ready;

  rbf_pkg::addr_t addr_beat;
  logic           addr_valid;
  logic           addr_ready;

  // Join, |x - grid| and multiply by scale
  scaled_diff u_scaled_diff (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_beat      (x_beat),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .grid_beat   (grid_beat),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .scale_beat  (scale_beat),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .prod_beat   (prod_beat),
    .prod_valid  (prod_valid),
    .prod_ready  (prod_ready)
  );

  diff_clamp u_diff_clamp (
    .clk        (clk),
    .rst_n      (rst_n),
    .prod_beat  (prod_beat),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .addr_beat  (addr_beat),
    .addr_valid (addr_valid),
    .addr_ready (addr_ready)
  );

  rbf_rom u_rbf_rom (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr_beat  (addr_beat),
    .addr_valid (addr_valid),
    .addr_ready (addr_ready),
    .rslt_beat  (rslt_beat),
    .rslt_valid (rslt_valid),
    .rslt_ready (rslt_ready)
  );

endmodule

//--- verification/rbf_unit_assertions.sv
`timescale 1ns/1ps

module rbf_unit_assertions (
  input logic           clk,
  input logic           rst_n,
  input logic           x_valid,
  input logic           grid_valid,
  input logic           scale_valid,
  input logic           x_ready,
  input logic           grid_ready,
  input logic           scale_ready,
  input rbf_pkg::rslt_t rslt_beat,
  input logic           rslt_valid,
  input logic           rslt_ready
);

  // Stalled result holds still
  hold_rslt: assert property (@(posedge clk) disable iff (!rst_n)
    rslt_valid && !rslt_ready |=> rslt_valid && $stable(rslt_beat))
  else $error("result beat changed while stalled");

  // Join only with all three valids up
  join_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (x_ready || grid_ready || scale_ready) |-> (x_valid && grid_valid && scale_valid))
  else $error("input ready raised without all three valids");

  reset_idle: assert property (@(posedge clk)
    !rst_n |-> !rslt_valid)
  else $error("result valid high during reset");

endmodule

bind rbf_unit rbf_unit_assertions u_rbf_unit_assertions (
  .clk         (clk),
  .rst_n       (rst_n),
  .x_valid     (x_valid),
  .grid_valid  (grid_valid),
  .scale_valid (scale_valid),
  .x_ready     (x_ready),
  .grid_ready  (grid_ready),
  .scale_ready (scale_ready),
  .rslt_beat   (rslt_beat),
  .rslt_valid  (rslt_valid),
  .rslt_ready  (rslt_ready)
);

//--- verification/rbf_model.svh
`ifndef RBF_MODEL_SVH
`define RBF_MODEL_SVH

// Galois LFSR state, stepped once per random bit
logic [31:0] lfsr_state;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

function automatic logic [31:0] take_bits(input int n);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    bits = {bits[30:0], lfsr_state[0]};
  end
  return bits;
endfunction

// |x - grid| * scale, moved from 24 to 5 fractional bits, clamped at 255
function automatic int expected_addr(input logic [15:0] x, input logic [15:0] grid,
                                     input logic [15:0] scale);
  int     d;
  int     mag;
  longint prod;
  longint sh;
  d    = int'($signed(x)) - int'($signed(grid));
  mag  = (d < 0) ? -d : d;
  prod = longint'(mag) * longint'(scale);
  sh   = prod >> 19;
  if (sh > 64'sd255) begin
    return 255;
  end
  return int'(sh);
endfunction

// 1.0 / cosh^2 in Q1.15, the top address reads as zero
function automatic int expected_rslt(input int addr);
  real t;
  real c;
  if (addr == 255) begin
    return 0;
  end
  t = addr / 32.0;
  c = ($exp(t) + $exp(-t)) / 2.0;
  return $rtoi(32768.0 / (c * c) + 0.5);
endfunction

`endif

//--- verification/rbf_unit_tb.sv
`timescale 1ns/1ps

module rbf_unit_tb;

  localparam int wait_limit   = 200;
  localparam int random_beats = 400;
  localparam int stall_beats  = 400;

  logic             clk;
  logic             rst_n;
  rbf_pkg::sample_t x_beat;
  rbf_pkg::sample_t grid_beat;
  rbf_pkg::sample_t scale_beat;
  logic             x_valid;
  logic             grid_valid;
  logic             scale_valid;
  logic             x_ready;
  logic             grid_ready;
  logic             scale_ready;
  rbf_pkg::rslt_t   rslt_beat;
  logic             rslt_valid;
  logic             rslt_ready;

  // Scoreboard, one entry per accepted input beat
  rbf_pkg::rslt_t   exp_q[$];
  int               acc_cycle_q[$];
  int               cycle = 0;
  int               n_accepted = 0;
  int               n_results = 0;
  int               last_latency = 0;
  rbf_pkg::rslt_t   last_out;

  `include "rbf_model.svh"

  rbf_unit u_rbf_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_beat      (x_beat),
    .x_valid     (x_valid),
    .x_ready     (x_ready),
    .grid_beat   (grid_beat),
    .grid_valid  (grid_valid),
    .grid_ready  (grid_ready),
    .scale_beat  (scale_beat),
    .scale_valid (scale_valid),
    .scale_ready (scale_ready),
    .rslt_beat   (rslt_beat),
    .rslt_valid  (rslt_valid),
    .rslt_ready  (rslt_ready)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic stop_run();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Handshakes sampled mid-cycle, where everything has settled
  always @(negedge clk) begin
    rbf_pkg::rslt_t e;
    int             acc;
    logic           hs_x;
    logic           hs_g;
    logic           hs_s;
    hs_x = x_valid && x_ready;
    hs_g = grid_valid && grid_ready;
    hs_s = scale_valid && scale_ready;
    if (rst_n) begin
      if (hs_x && hs_g && hs_s) begin
        e.value = 16'(expected_rslt(expected_addr(x_beat.value, grid_beat.value,
                                                  scale_beat.value)));
        e.last  = x_beat.last | grid_beat.last | scale_beat.last;
        exp_q.push_back(e);
        acc_cycle_q.push_back(cycle);
        n_accepted = n_accepted + 1;
      end else if (hs_x || hs_g || hs_s) begin
        $display("input streams moved without a full join at %0t", $time);
        stop_run();
      end
      if (rslt_valid && rslt_ready) begin
        if (exp_q.size() == 0) begin
          $display("result at %0t with no input beat pending", $time);
          stop_run();
        end else begin
          e   = exp_q.pop_front();
          acc = acc_cycle_q.pop_front();
          check_value(32'(rslt_beat.value), 32'(e.value), "result value");
          check_value(32'(rslt_beat.last), 32'(e.last), "result last");
          last_out     = rslt_beat;
          last_latency = cycle - acc;
          n_results    = n_results + 1;
        end
      end
    end
  end

  // Fresh triple, mostly aimed inside the table
  task automatic new_triple();
    logic [31:0] kind;
    logic [31:0] r;
    logic [15:0] x;
    logic [15:0] offset;
    kind = take_bits(2);
    x    = 16'(take_bits(16));
    x_beat.value = x;
    case (kind[1:0])
      2'd0: begin
        grid_beat.value  = 16'(take_bits(16));
        scale_beat.value = 16'(take_bits(16));
      end
      2'd1: begin
        r      = take_bits(14);
        offset = {{2{r[13]}}, r[13:0]};
        grid_beat.value = x - offset;
        r      = take_bits(14);
        scale_beat.value = {2'b00, r[13:0]};
      end
      2'd2: begin
        grid_beat.value  = x;
        scale_beat.value = 16'(take_bits(16));
      end
      default: begin
        grid_beat.value  = 16'(take_bits(16));
        scale_beat.value = 16'h0000;
      end
    endcase
    x_beat.last     = (take_bits(2) == 0);
    grid_beat.last  = (take_bits(2) == 0);
    scale_beat.last = (take_bits(2) == 0);
    x_valid     = 1'b0;
    grid_valid  = 1'b0;
    scale_valid = 1'b0;
  endtask

  // Per-stream valid gaps, optional output stalls
  task automatic run_random(input int n_beats, input logic stall);
    int target;
    int seen;
    int idle;
    target = n_accepted + n_beats;
    seen   = n_accepted;
    idle   = 0;
    new_triple();
    while (n_accepted < target) begin
      if (!x_valid) x_valid = (take_bits(2) != 0);
      if (!grid_valid) grid_valid = (take_bits(2) != 0);
      if (!scale_valid) scale_valid = (take_bits(2) != 0);
      rslt_ready = stall ? (take_bits(2) != 0) : 1'b1;
      @(posedge clk);
      #1;
      idle++;
      if (n_accepted != seen) begin
        seen = n_accepted;
        idle = 0;
        new_triple();
      end
      if (idle > wait_limit) begin
        $display("random stream stalled with no input accepted");
        stop_run();
      end
    end
    x_valid     = 1'b0;
    grid_valid  = 1'b0;
    scale_valid = 1'b0;
    rslt_ready  = 1'b1;
  endtask

  task automatic send_isolated(input logic [15:0] x, input logic [15:0] g,
                               input logic [15:0] s, input logic lx, input logic lg,
                               input logic ls);
    int start_acc;
    int start_res;
    int cnt;
    start_acc = n_accepted;
    start_res = n_results;
    x_beat.value     = x;
    x_beat.last      = lx;
    grid_beat.value  = g;
    grid_beat.last   = lg;
    scale_beat.value = s;
    scale_beat.last  = ls;
    x_valid     = 1'b1;
    grid_valid  = 1'b1;
    scale_valid = 1'b1;
    rslt_ready  = 1'b1;
    cnt = 0;
    while (n_accepted == start_acc) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > wait_limit) begin
        $display("isolated beat was never accepted");
        stop_run();
      end
    end
    x_valid     = 1'b0;
    grid_valid  = 1'b0;
    scale_valid = 1'b0;
    cnt = 0;
    while (n_results == start_res) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > wait_limit) begin
        $display("isolated beat produced no result");
        stop_run();
      end
    end
    check_value(last_latency, 4, "isolated beat latency");
  endtask

  task automatic drain();
    int cnt;
    rslt_ready = 1'b1;
    cnt = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt > wait_limit) begin
        $display("results still pending after drain");
        stop_run();
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b1;
    lfsr_state = 32'h297d_f1fc;
    x_beat      = '0;
    grid_beat   = '0;
    scale_beat  = '0;
    x_valid     = 1'b0;
    grid_valid  = 1'b0;
    scale_valid = 1'b0;
    rslt_ready  = 1'b0;
    #10;
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    send_isolated(16'h0800, 16'h0000, 16'h1000, 1'b0, 1'b0, 1'b0);
    send_isolated(16'hf400, 16'h0400, 16'h0100, 1'b1, 1'b0, 1'b0);
    run_random(random_beats, 1'b0);
    run_random(stall_beats, 1'b1);
    drain();

    // Corners past the table, zero scale and zero difference
    send_isolated(16'h7fff, 16'h8000, 16'hffff, 1'b0, 1'b1, 1'b0);
    check_value(32'(last_out.value), 0, "saturated difference");
    check_value(32'(last_out.last), 1, "last from grid");
    send_isolated(16'h1000, 16'h0000, 16'h8000, 1'b0, 1'b0, 1'b0);
    check_value(32'(last_out.value), 0, "product just past the table");
    check_value(32'(last_out.last), 0, "no last");
    send_isolated(16'h1234, 16'hedcc, 16'h0000, 1'b0, 1'b0, 1'b1);
    check_value(32'(last_out.value), 32768, "zero scale");
    check_value(32'(last_out.last), 1, "last from scale");
    send_isolated(16'h5a5a, 16'h5a5a, 16'hffff, 1'b0, 1'b0, 1'b0);
    check_value(32'(last_out.value), 32768, "equal x and grid");

    if (exp_q.size() == 0 && n_results == n_accepted) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("%0d results missing at end of run", n_accepted - n_results);
      stop_run();
    end
  end

endmodule

//--- sim.f
+incdir+verification
hdl/rbf_pkg.sv
hdl/scaled_diff.sv
hdl/diff_clamp.sv
hdl/rbf_rom.sv
hdl/rbf_unit.sv
verification/rbf_unit_assertions.sv
verification/rbf_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= rbf_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
